// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int addr_bits   = 32;
    localparam int word_bits   = 32;
    localparam int byte_lanes  = 4;
    localparam int index_bits  = 4;
    localparam int offset_bits = 2;
    localparam int tag_bits    = addr_bits - index_bits - offset_bits;
    localparam int num_lines   = 1 << index_bits;

    typedef enum logic [6:0] {
        op_load  = 7'h03,
        op_store = 7'h23
    } opcode_e;

    // values follow funct3
    typedef enum logic [2:0] {
        acc_byte   = 3'd0,
        acc_half   = 3'd1,
        acc_word   = 3'd2,
        acc_byte_u = 3'd4,
        acc_half_u = 3'd5
    } access_e;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill,
        st_respond
    } cache_state_e;

    typedef struct packed {
        logic                    is_store;
        access_e                 kind;
        logic [tag_bits-1:0]     tag;
        logic [index_bits-1:0]   index;
        logic [offset_bits-1:0]  offset;
        logic [word_bits-1:0]    wdata;
        logic [byte_lanes-1:0]   be;
    } cache_access_t;

    typedef struct packed {
        logic                    start;
        logic                    we;
        logic [addr_bits-1:0]    addr;
        logic [word_bits-1:0]    wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    en;
        logic [index_bits-1:0]   index;
        logic [byte_lanes-1:0]   be;
        logic [word_bits-1:0]    data;
        logic                    set_valid;
        logic                    set_dirty;
        logic [tag_bits-1:0]     tag;
    } line_wr_t;

endpackage

`default_nettype wire

// ==== source/cache_req_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_req_decoder import cache_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 req_valid,
    input  logic [6:0]           req_opcode,
    input  logic [2:0]           req_funct3,
    input  logic [addr_bits-1:0] req_addr,
    input  logic [word_bits-1:0] req_wdata,
    input  logic                 busy,
    output logic                 ready,
    output logic                 acc_valid,
    output cache_access_t        acc
);

    logic                   accept;
    logic                   is_store;
    logic                   is_mem;
    logic [offset_bits-1:0] offset;
    logic [2*word_bits-1:0] doubled;
    logic [word_bits-1:0]   lane_data;
    logic [byte_lanes-1:0]  lane_be;
    cache_access_t          acc_nx;

    assign ready    = !busy && !acc_valid;
    assign accept   = req_valid && ready;
    assign offset   = req_addr[offset_bits-1:0];
    assign is_store = (req_opcode == op_store);
    assign is_mem   = is_store || (req_opcode == op_load);

    // rotate left so byte 0 of the store data sits in the addressed lane
    assign doubled = {req_wdata, req_wdata} << {offset, 3'b000};

    always_comb begin
        lane_data = req_wdata;
        lane_be   = '0;
        if (is_store) begin
            case (access_e'(req_funct3))
                acc_byte: begin
                    lane_data = doubled[2*word_bits-1:word_bits];
                    lane_be   = 4'b0001 << offset;
                end
                acc_half: begin
                    lane_data = doubled[2*word_bits-1:word_bits];
                    case (offset)
                        2'd0:    lane_be = 4'b0011;
                        2'd1:    lane_be = 4'b0110;
                        2'd2:    lane_be = 4'b1100;
                        default: lane_be = 4'b1001;
                    endcase
                end
                // word ignores the offset
                acc_word: lane_be = '1;
                default:  lane_be = '0;
            endcase
        end
    end

    always_comb begin
        acc_nx.is_store = is_store;
        acc_nx.kind     = access_e'(req_funct3);
        acc_nx.tag      = req_addr[addr_bits-1 -: tag_bits];
        acc_nx.index    = req_addr[offset_bits +: index_bits];
        acc_nx.offset   = offset;
        acc_nx.wdata    = lane_data;
        acc_nx.be       = lane_be;
    end

    // other opcodes are taken and dropped
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= accept && is_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acc <= acc_nx;
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_line_store import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic [index_bits-1:0] rd_index,
    output logic                  rd_valid,
    output logic                  rd_dirty,
    output logic [tag_bits-1:0]   rd_tag,
    output logic [word_bits-1:0]  rd_data,
    input  line_wr_t              wr
);

    logic                 valid_q [num_lines];
    logic                 dirty_q [num_lines];
    logic [tag_bits-1:0]  tag_q   [num_lines];
    logic [word_bits-1:0] data_q  [num_lines];

    assign rd_valid = valid_q[rd_index];
    assign rd_dirty = dirty_q[rd_index];
    assign rd_tag   = tag_q[rd_index];
    assign rd_data  = data_q[rd_index];

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < num_lines; i++) begin
                valid_q[i] <= 1'b0;
                dirty_q[i] <= 1'b0;
            end
        end else if (wr.en) begin
            valid_q[wr.index] <= wr.set_valid;
            dirty_q[wr.index] <= wr.set_dirty;
        end
    end

    // byte merge into the selected line
    always_ff @(posedge clk) begin
        if (wr.en) begin
            tag_q[wr.index] <= wr.tag;
            for (int b = 0; b < byte_lanes; b++) begin
                if (wr.be[b]) begin
                    data_q[wr.index][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_load_format.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_load_format import cache_pkg::*; (
    input  logic [word_bits-1:0]   word,
    input  access_e                kind,
    input  logic [offset_bits-1:0] offset,
    output logic [word_bits-1:0]   result
);

    logic [2*word_bits-1:0] doubled;
    logic [7:0]             byte_sel;
    logic [15:0]            half_sel;

    // rotate right so the addressed byte ends up in lane 0
    // halfword at offset 3 wraps around to lane 0 for its high byte
    assign doubled  = {word, word} >> {offset, 3'b000};
    assign byte_sel = doubled[7:0];
    assign half_sel = doubled[15:0];

    always_comb begin
        case (kind)
            acc_byte:   result = {{(word_bits-8){byte_sel[7]}}, byte_sel};
            acc_half:   result = {{(word_bits-16){half_sel[15]}}, half_sel};
            acc_word:   result = word;
            acc_byte_u: result = {{(word_bits-8){1'b0}}, byte_sel};
            acc_half_u: result = {{(word_bits-16){1'b0}}, half_sel};
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic                  acc_valid,
    input  cache_access_t         acc,
    output logic                  busy,
    output logic [index_bits-1:0] index,
    input  logic                  line_valid,
    input  logic                  line_dirty,
    input  logic [tag_bits-1:0]   line_tag,
    input  logic [word_bits-1:0]  line_data,
    output line_wr_t              line_wr,
    output mem_req_t              mem_req,
    input  logic                  mem_done,
    input  logic [word_bits-1:0]  mem_rdata,
    output logic                  resp_valid,
    output logic [word_bits-1:0]  resp_rdata
);

    cache_state_e         state;
    mem_req_t             mem_q;
    logic                 hit;
    logic                 refill_done;
    logic [word_bits-1:0] load_word;

    assign index       = acc.index;
    assign hit         = line_valid && (line_tag == acc.tag);
    assign busy        = (state != st_idle);
    assign mem_req     = mem_q;
    assign refill_done = (state == st_refill) && mem_q.start && mem_done;
    assign resp_valid  = (state == st_respond);
    assign resp_rdata  = (resp_valid && !acc.is_store) ? load_word : '0;

    cache_load_format u_load_format (
        .word   (line_data),
        .kind   (acc.kind),
        .offset (acc.offset),
        .result (load_word)
    );

    // tag compare happens in the acc_valid cycle
    // so a hit answers on the next one
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state <= st_idle;
            mem_q <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (acc_valid) begin
                        state <= hit ? st_respond : st_lookup;
                    end
                end
                st_lookup: begin
                    if (line_valid && line_dirty) begin
                        mem_q.start <= 1'b1;
                        mem_q.we    <= 1'b1;
                        mem_q.addr  <= {line_tag, acc.index, {offset_bits{1'b0}}};
                        mem_q.wdata <= line_data;
                        state       <= st_writeback;
                    end else begin
                        state <= st_refill;
                    end
                end
                st_writeback: begin
                    if (mem_done) begin
                        mem_q.start <= 1'b0;
                        mem_q.we    <= 1'b0;
                        state       <= st_refill;
                    end
                end
                st_refill: begin
                    // start drops for a cycle between the two transfers
                    if (!mem_q.start) begin
                        mem_q.start <= 1'b1;
                        mem_q.we    <= 1'b0;
                        mem_q.addr  <= {acc.tag, acc.index, {offset_bits{1'b0}}};
                    end else if (mem_done) begin
                        mem_q.start <= 1'b0;
                        state       <= st_respond;
                    end
                end
                st_respond: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // refill lands clean, a store merges on top in the respond cycle
    always_comb begin
        line_wr           = '0;
        line_wr.index     = acc.index;
        line_wr.tag       = acc.tag;
        line_wr.set_valid = 1'b1;
        if (refill_done) begin
            line_wr.en        = 1'b1;
            line_wr.be        = '1;
            line_wr.data      = mem_rdata;
            line_wr.set_dirty = 1'b0;
        end else if (resp_valid && acc.is_store && (acc.be != '0)) begin
            line_wr.en        = 1'b1;
            line_wr.be        = acc.be;
            line_wr.data      = acc.wdata;
            line_wr.set_dirty = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 req_valid,
    input  logic [6:0]           req_opcode,
    input  logic [2:0]           req_funct3,
    input  logic [addr_bits-1:0] req_addr,
    input  logic [word_bits-1:0] req_wdata,
    output logic                 ready,
    output logic                 resp_valid,
    output logic [word_bits-1:0] resp_rdata,
    output mem_req_t             mem_req,
    input  logic                 mem_done,
    input  logic [word_bits-1:0] mem_rdata
);

    logic                  acc_valid;
    cache_access_t         acc;
    logic                  busy;
    logic [index_bits-1:0] line_index;
    logic                  line_valid;
    logic                  line_dirty;
    logic [tag_bits-1:0]   line_tag;
    logic [word_bits-1:0]  line_data;
    line_wr_t              line_wr;

    cache_req_decoder u_decoder (
        .clk        (clk),
        .rst_b      (rst_b),
        .req_valid  (req_valid),
        .req_opcode (req_opcode),
        .req_funct3 (req_funct3),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .busy       (busy),
        .ready      (ready),
        .acc_valid  (acc_valid),
        .acc        (acc)
    );

    cache_line_store u_line_store (
        .clk      (clk),
        .rst_b    (rst_b),
        .rd_index (line_index),
        .rd_valid (line_valid),
        .rd_dirty (line_dirty),
        .rd_tag   (line_tag),
        .rd_data  (line_data),
        .wr       (line_wr)
    );

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst_b      (rst_b),
        .acc_valid  (acc_valid),
        .acc        (acc),
        .busy       (busy),
        .index      (line_index),
        .line_valid (line_valid),
        .line_dirty (line_dirty),
        .line_tag   (line_tag),
        .line_data  (line_data),
        .line_wr    (line_wr),
        .mem_req    (mem_req),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata)
    );

endmodule

`default_nettype wire

// ==== sim/tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache import cache_pkg::*; ();

    localparam int          num_requests = 400;
    localparam int          period_ns    = 100;
    localparam int          timeout_ns   = (num_requests * 16 + 10) * period_ns;
    localparam logic [31:0] addr_base    = 32'h0001_0000;

    logic                clk;
    logic                rst_b;
    logic                req_valid;
    logic [6:0]          req_opcode;
    logic [2:0]          req_funct3;
    logic [31:0]         req_addr;
    logic [31:0]         req_wdata;
    logic                ready;
    logic                resp_valid;
    logic [31:0]         resp_rdata;
    mem_req_t            mem_req;
    logic                mem_done;
    logic [31:0]         mem_rdata;

    // backing memory, the core's byte view, and the line mirror
    logic [31:0]         mem_words [logic [31:0]];
    logic [7:0]          flat_bytes [256];
    logic                mir_valid [num_lines];
    logic                mir_dirty [num_lines];
    logic [tag_bits-1:0] mir_tag [num_lines];

    // transfers the memory model expects next
    logic                exp_wr_pending;
    logic                exp_rd_pending;
    logic [31:0]         exp_wr_addr;
    logic [31:0]         exp_wr_data;
    logic [31:0]         exp_rd_addr;
    int                  mem_xfers;
    int                  resp_count;
    int                  resp_expected;
    int unsigned         seed;

    cache_top dut (
        .clk        (clk),
        .rst_b      (rst_b),
        .req_valid  (req_valid),
        .req_opcode (req_opcode),
        .req_funct3 (req_funct3),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .ready      (ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .mem_req    (mem_req),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata)
    );

    always #(period_ns / 2) clk = ~clk;

    always @(negedge clk) begin
        if (resp_valid) begin
            resp_count++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string what);
        $display("%0t ns error: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [7:0] flat_index(input logic [31:0] a, input logic [1:0] lane);
        logic [31:0] ofs;
        ofs = a - addr_base;
        return {ofs[7:2], lane};
    endfunction

    function automatic logic [31:0] flat_word(input logic [31:0] a);
        return {flat_bytes[flat_index(a, 2'd3)], flat_bytes[flat_index(a, 2'd2)],
                flat_bytes[flat_index(a, 2'd1)], flat_bytes[flat_index(a, 2'd0)]};
    endfunction

    task automatic store_flat_word(input logic [31:0] a, input logic [31:0] d);
        flat_bytes[flat_index(a, 2'd0)] = d[7:0];
        flat_bytes[flat_index(a, 2'd1)] = d[15:8];
        flat_bytes[flat_index(a, 2'd2)] = d[23:16];
        flat_bytes[flat_index(a, 2'd3)] = d[31:24];
    endtask

    // halfword high byte wraps to lane 0 at offset 3
    function automatic logic [31:0] expected_load(input logic [31:0] a, input logic [2:0] f3);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = flat_bytes[flat_index(a, a[1:0])];
        hi = flat_bytes[flat_index(a, a[1:0] + 2'd1)];
        case (f3)
            3'd0:    return {{24{lo[7]}}, lo};
            3'd1:    return {{16{hi[7]}}, hi, lo};
            3'd2:    return flat_word(a);
            3'd4:    return {24'b0, lo};
            3'd5:    return {16'b0, hi, lo};
            default: return '0;
        endcase
    endfunction

    task automatic apply_store(input logic [31:0] a, input logic [2:0] f3, input logic [31:0] d);
        case (f3)
            3'd0: flat_bytes[flat_index(a, a[1:0])] = d[7:0];
            3'd1: begin
                flat_bytes[flat_index(a, a[1:0])]         = d[7:0];
                flat_bytes[flat_index(a, a[1:0] + 2'd1)] = d[15:8];
            end
            3'd2:    store_flat_word(a, d);
            default: ;
        endcase
    endtask

    task automatic run_request(input logic [6:0] opcode, input logic [2:0] funct3,
                               input logic [31:0] addr, input logic [31:0] wdata);
        logic                  is_mem;
        logic                  is_store;
        logic                  hit;
        logic                  store_ok;
        logic [index_bits-1:0] idx;
        logic [tag_bits-1:0]   tag;
        logic [31:0]           exp_rdata;
        int                    cycles;
        int                    xfers_before;
        int                    exp_xfers;
        is_store  = (opcode == 7'h23);
        is_mem    = is_store || (opcode == 7'h03);
        store_ok  = is_store && (funct3 <= 3'd2);
        idx       = addr[5:2];
        tag       = addr[31:6];
        hit       = mir_valid[idx] && (mir_tag[idx] == tag);
        exp_xfers = 0;
        if (is_mem && !hit) begin
            exp_rd_addr    = {tag, idx, 2'b00};
            exp_rd_pending = 1'b1;
            exp_xfers      = 1;
            if (mir_valid[idx] && mir_dirty[idx]) begin
                exp_wr_addr    = {mir_tag[idx], idx, 2'b00};
                exp_wr_data    = flat_word(exp_wr_addr);
                exp_wr_pending = 1'b1;
                exp_xfers      = 2;
            end
        end
        xfers_before = mem_xfers;
        req_valid  = 1'b1;
        req_opcode = opcode;
        req_funct3 = funct3;
        req_addr   = addr;
        req_wdata  = wdata;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        cycles    = 1;
        if (!is_mem) begin
            check_value("resp_valid", 32'(resp_valid), 0);
            @(posedge clk);
            #1;
            check_value("resp_valid", 32'(resp_valid), 0);
            check_value("ready", 32'(ready), 1);
        end else begin
            while (!resp_valid) begin
                if (cycles >= 16) begin
                    abort_run("no response from the cache within 16 cycles");
                end
                @(posedge clk);
                #1;
                cycles++;
            end
            if (hit) begin
                check_value("hit latency", cycles, 2);
            end
            exp_rdata = is_store ? '0 : expected_load(addr, funct3);
            check_value("resp_rdata", resp_rdata, exp_rdata);
            check_value("memory transfers", mem_xfers - xfers_before, exp_xfers);
            if (store_ok) begin
                apply_store(addr, funct3, wdata);
            end
            mir_dirty[idx] = (hit && mir_dirty[idx]) || store_ok;
            mir_valid[idx] = 1'b1;
            mir_tag[idx]   = tag;
            resp_expected++;
            @(posedge clk);
            #1;
            check_value("resp_valid", 32'(resp_valid), 0);
            check_value("ready", 32'(ready), 1);
            check_value("response count", resp_count, resp_expected);
        end
    endtask

    // memory model answers after 1 to 4 cycles
    initial begin
        logic [31:0] rnd;
        mem_done  = 1'b0;
        mem_rdata = '0;
        @(posedge rst_b);
        forever begin
            @(posedge clk);
            #1;
            if (mem_req.start) begin
                rnd = $urandom;
                repeat (rnd[1:0]) begin
                    @(posedge clk);
                    #1;
                end
                if (mem_req.we) begin
                    if (!exp_wr_pending) begin
                        abort_run("memory write without a dirty line to evict");
                    end
                    check_value("mem_req.addr", mem_req.addr, exp_wr_addr);
                    check_value("mem_req.wdata", mem_req.wdata, exp_wr_data);
                    mem_words[mem_req.addr] = mem_req.wdata;
                    exp_wr_pending = 1'b0;
                end else begin
                    if (exp_wr_pending || !exp_rd_pending) begin
                        abort_run("memory read that the cache state does not call for");
                    end
                    check_value("mem_req.addr", mem_req.addr, exp_rd_addr);
                    mem_rdata      = mem_words[mem_req.addr];
                    exp_rd_pending = 1'b0;
                end
                mem_xfers++;
                mem_done = 1'b1;
                @(posedge clk);
                #1;
                mem_done = 1'b0;
                check_value("mem_req.start", 32'(mem_req.start), 0);
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog: run still going after %0d ns", timeout_ns);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] word;
        logic [6:0]  opcode;
        seed = 32'h903e_2cd0;
        void'($urandom(seed));
        clk            = 1'b0;
        rst_b          = 1'b0;
        req_valid      = 1'b0;
        req_opcode     = '0;
        req_funct3     = '0;
        req_addr       = '0;
        req_wdata      = '0;
        exp_wr_pending = 1'b0;
        exp_rd_pending = 1'b0;
        exp_wr_addr    = '0;
        exp_wr_data    = '0;
        exp_rd_addr    = '0;
        mem_xfers      = 0;
        resp_count     = 0;
        resp_expected  = 0;
        mir_valid      = '{default: 1'b0};
        mir_dirty      = '{default: 1'b0};
        mir_tag        = '{default: '0};
        for (int w = 0; w < 64; w++) begin
            addr            = addr_base + 32'(w) * 32'd4;
            word            = $urandom;
            mem_words[addr] = word;
            store_flat_word(addr, word);
        end
        repeat (5) @(posedge clk);
        #1;
        rst_b = 1'b1;
        check_value("ready", 32'(ready), 1);
        check_value("resp_valid", 32'(resp_valid), 0);
        check_value("mem_req.start", 32'(mem_req.start), 0);
        check_value("mem_req.we", 32'(mem_req.we), 0);

        // 64 words over 16 lines, so indexes collide often
        for (int n = 0; n < num_requests; n++) begin
            rnd  = $urandom;
            addr = addr_base + {24'b0, rnd[5:0], rnd[7:6]};
            if (rnd[15:12] == 4'hf) begin
                case (rnd[17:16])
                    2'd0:    opcode = 7'h13;
                    2'd1:    opcode = 7'h33;
                    2'd2:    opcode = 7'h37;
                    default: opcode = 7'h73;
                endcase
            end else begin
                opcode = rnd[11] ? 7'h23 : 7'h03;
            end
            word = $urandom;
            run_request(opcode, rnd[10:8], addr, word);
        end

        repeat (4) @(posedge clk);
        #1;
        check_value("response count", resp_count, resp_expected);
        check_value("mem_req.start", 32'(mem_req.start), 0);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
source/cache_pkg.sv
source/cache_req_decoder.sv
source/cache_line_store.sv
source/cache_load_format.sv
source/cache_ctrl.sv
source/cache_top.sv
sim/tb_cache.sv

// ==== Makefile ====
TB_TOP = tb_cache

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module cache_top -f src.f

sim:
	verilator --binary --timing --top-module $(TB_TOP) -f src.f
	./obj_dir/V$(TB_TOP) | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
